//--- src.f
logic/cw_reg_pkg.sv
logic/usb_reg_bridge.sv
logic/reg_target_io.sv
logic/reg_adc_serial.sv
logic/status_leds.sv
logic/cw_usb_regs_top.sv
bench/cw_usb_regs_sva.sv
bench/tb_cw_usb_regs.sv

//--- run_sim.sh
#!/bin/sh
# build and run the register subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_cw_usb_regs -Mdir "$OBJ" -f src.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# keep running after an assertion error so the testbench reports the result
"./$OBJ/Vtb_cw_usb_regs" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- bench/tb_cw_usb_regs.sv
`timescale 1ns/10ps

module tb_cw_usb_regs;

   import cw_reg_pkg::*;

   localparam int BYTECNT_W  = 7;
   localparam int SCLK_DIV   = 2;
   localparam int BEAT_W     = 6;
   localparam int LED_WIN    = 1 << BEAT_W;
   localparam int XFER_LIMIT = 40 * SCLK_DIV;   // full transfer is 32 * div

   typedef enum int {OP_WR, OP_RD, OP_RD2, OP_IO, OP_TRIG, OP_XFER, OP_BUSY, OP_ERR} op_t;

   logic       clk_usb_buf;
   logic       rst_n_i;
   logic       usb_cen_i;
   logic       usb_alen_i;
   logic       usb_wrn_i;
   logic       usb_rdn_i;
   reg_addr_t  usb_addr_i;
   reg_data_t  usb_din_i;
   reg_data_t  usb_dout_o;
   logic       usb_isout_o;
   logic [3:0] target_io_i;
   logic       trig_out_o;
   logic [3:0] target_oe_o;
   logic [3:0] target_out_o;
   logic       adc_sclk_o;
   logic       adc_sdata_o;
   logic       adc_sen_o;
   logic       adc_sdout_i;
   logic       led_beat_o;
   logic       led_clk1fail_o;
   logic       led_clk2fail_o;

   // test table
   string      tname_q[$];
   op_t        op_q[$];
   reg_addr_t  addr_q[$];
   adc_word_t  data_q[$];
   adc_word_t  exp_q[$];
   bit         table_built = 1'b0;

   int         err_cnt = 0;
   integer     seed = 32'h5c88fe38;

   // serial model state
   adc_word_t  reply_word;
   adc_word_t  reply_sh;
   adc_word_t  rx_word;
   int         rx_bits;

   cw_usb_regs_top #(
      .pBYTECNT_SIZE  (BYTECNT_W),
      .pSCLK_DIV      (SCLK_DIV),
      .pBEAT_WIDTH    (BEAT_W)
   ) u_dut (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .usb_cen_i      (usb_cen_i),
      .usb_alen_i     (usb_alen_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_addr_i     (usb_addr_i),
      .usb_din_i      (usb_din_i),
      .usb_dout_o     (usb_dout_o),
      .usb_isout_o    (usb_isout_o),
      .target_io_i    (target_io_i),
      .trig_out_o     (trig_out_o),
      .target_oe_o    (target_oe_o),
      .target_out_o   (target_out_o),
      .adc_sclk_o     (adc_sclk_o),
      .adc_sdata_o    (adc_sdata_o),
      .adc_sen_o      (adc_sen_o),
      .adc_sdout_i    (adc_sdout_i),
      .led_beat_o     (led_beat_o),
      .led_clk1fail_o (led_clk1fail_o),
      .led_clk2fail_o (led_clk2fail_o)
   );

   always #4 clk_usb_buf = ~clk_usb_buf;   // 8 ns

   // ADC side of the serial port, reply shifted MSB first
   initial begin : serial_model
      adc_sdout_i = 1'b0;
      forever begin
         @(negedge adc_sen_o);
         reply_word = adc_word_t'($random(seed));
         reply_sh = reply_word;
         rx_word = '0;
         rx_bits = 0;
         adc_sdout_i <= reply_sh[15];
         while (rx_bits < 16) begin
            @(posedge adc_sclk_o);
            rx_word = {rx_word[14:0], adc_sdata_o};
            rx_bits++;
            reply_sh = {reply_sh[14:0], 1'b0};
            adc_sdout_i <= reply_sh[15];   // next bit during sclk low
         end
      end
   end

   task automatic add_test(input string name, input op_t op, input reg_addr_t addr,
                           input adc_word_t data, input adc_word_t exp);
      tname_q.push_back(name);
      op_q.push_back(op);
      addr_q.push_back(addr);
      data_q.push_back(data);
      exp_q.push_back(exp);
   endtask

   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      if (act !== exp) begin
         $display("ERR %s expected %02h actual %02h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_word(input string name, input adc_word_t exp, input adc_word_t act);
      if (act !== exp) begin
         $display("ERR %s expected %04h actual %04h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s expected %b actual %b", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic bus_addr(input reg_addr_t addr);
      @(posedge clk_usb_buf);
      usb_cen_i  <= 1'b0;
      usb_alen_i <= 1'b0;
      usb_addr_i <= addr;
      @(posedge clk_usb_buf);
      usb_cen_i  <= 1'b1;
      usb_alen_i <= 1'b1;
   endtask

   task automatic bus_write(input reg_data_t data);
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b0;
      usb_wrn_i <= 1'b0;
      usb_din_i <= data;
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b1;
      usb_wrn_i <= 1'b1;
   endtask

   // dout is valid two cycles after the sampled read cycle
   task automatic bus_read(input string name, output reg_data_t data);
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b0;
      usb_rdn_i <= 1'b0;
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b1;
      usb_rdn_i <= 1'b1;
      @(negedge clk_usb_buf);
      check_bit({name, " isout"}, 1'b1, usb_isout_o);   // one cycle behind rdn
      @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      check_bit({name, " isout"}, 1'b0, usb_isout_o);
      data = usb_dout_o;
   endtask

   task automatic wait_sen(input string name, input logic level, input int limit);
      int n;
      n = 0;
      @(negedge clk_usb_buf);
      while (adc_sen_o !== level && n < limit) begin
         @(negedge clk_usb_buf);
         n++;
      end
      if (adc_sen_o !== level) begin
         $display("%s: adc_sen_o did not go to %b within %0d cycles", name, level, limit);
         err_cnt++;
      end
   endtask

   task automatic start_transfer(input string name, input adc_word_t word);
      bus_addr(REG_ADC_CFG);
      bus_write(word[15:8]);
      bus_write(word[7:0]);   // byte 1 launches
      wait_sen(name, 1'b0, 4);
   endtask

   task automatic check_led_toggle(input string name);
      logic first;
      bit   toggled;
      bit   tracks_beat;
      int   n;
      toggled = 1'b0;
      tracks_beat = 1'b1;
      @(negedge clk_usb_buf);
      first = led_clk1fail_o;
      for (n = 0; n < LED_WIN && !toggled; n++) begin
         @(negedge clk_usb_buf);
         if (led_clk1fail_o !== first) toggled = 1'b1;
         // both fail LEDs flash with the heartbeat while the error is set
         if (led_clk1fail_o !== led_beat_o || led_clk2fail_o !== led_beat_o) begin
            tracks_beat = 1'b0;
         end
      end
      if (!toggled) begin
         $display("%s: led_clk1fail_o did not toggle within %0d cycles", name, LED_WIN);
         err_cnt++;
      end
      if (!tracks_beat) begin
         $display("%s: fail LEDs did not follow led_beat_o while the error was set", name);
         err_cnt++;
      end
   endtask

   task automatic check_led_quiet(input string name);
      logic seen;
      bit   beat_hi;
      bit   beat_lo;
      int   n;
      seen = 1'b0;
      beat_hi = 1'b0;
      beat_lo = 1'b0;
      for (n = 0; n < 2 * LED_WIN; n++) begin
         @(negedge clk_usb_buf);
         seen = seen | led_clk1fail_o | led_clk2fail_o;
         if (led_beat_o === 1'b1) beat_hi = 1'b1;
         if (led_beat_o === 1'b0) beat_lo = 1'b1;
      end
      check_bit(name, 1'b0, seen);
      if (!(beat_hi && beat_lo)) begin
         $display("%s: led_beat_o did not toggle within %0d cycles", name, 2 * LED_WIN);
         err_cnt++;
      end
   endtask

   task automatic run_test(input string name, input op_t op, input reg_addr_t addr,
                           input adc_word_t data, input adc_word_t exp);
      reg_data_t d;
      case (op)
         OP_WR: begin
            bus_addr(addr);
            bus_write(data[7:0]);
         end
         OP_RD: begin
            bus_addr(addr);
            bus_read(name, d);
            check_data(name, exp[7:0], d);
         end
         OP_RD2: begin
            bus_addr(addr);
            bus_read(name, d);
            check_data(name, exp[15:8], d);
            bus_read(name, d);
            check_data(name, exp[7:0], d);
         end
         OP_IO: begin
            bus_addr(addr);
            bus_write(data[7:0]);
            @(posedge clk_usb_buf);
            @(negedge clk_usb_buf);
            check_data(name, exp[7:0], {target_out_o, target_oe_o});
         end
         OP_TRIG: begin
            bus_addr(addr);
            bus_write(data[7:0]);   // mask
            @(posedge clk_usb_buf);
            target_io_i <= data[11:8];
            repeat (2) @(posedge clk_usb_buf);
            @(negedge clk_usb_buf);
            check_bit(name, exp[0], trig_out_o);
         end
         OP_XFER: begin
            start_transfer(name, data);
            wait_sen(name, 1'b1, XFER_LIMIT);
            check_word(name, data, rx_word);
            check_data(name, 8'd16, reg_data_t'(rx_bits));
            bus_addr(REG_ADC_STAT);
            bus_read(name, d);
            check_data(name, exp[7:0], d);   // busy clear
            bus_read(name, d);
            check_data(name, reply_word[7:0], d);
         end
         OP_BUSY: begin
            start_transfer(name, data);
            bus_addr(addr);
            bus_read(name, d);
            check_data(name, exp[7:0], d);
            bus_addr(addr);   // count back to byte 0
            bus_read(name, d);
            check_data(name, exp[7:0], d);
            wait_sen(name, 1'b1, XFER_LIMIT);
            check_word(name, data, rx_word);
         end
         OP_ERR: begin
            start_transfer(name, data);
            bus_addr(REG_ADC_CFG);
            bus_write(8'h55);   // dropped, sets error
            wait_sen(name, 1'b1, XFER_LIMIT);
            check_word(name, data, rx_word);
            check_led_toggle(name);
            bus_addr(REG_ADC_STAT);
            bus_read(name, d);
            check_data(name, exp[7:0], d);
            check_led_quiet(name);
         end
         default: begin
            $display("%s: unknown table operation", name);
            err_cnt++;
         end
      endcase
   endtask

   initial begin : watchdog
      wait (table_built);
      repeat (tname_q.size() * 200) @(posedge clk_usb_buf);
      $display("watchdog: run exceeded %0d cycles", tname_q.size() * 200);
      $display("Result: FAILED");
      $finish;
   end

   initial begin : main
      int i;
      int err_before;
      clk_usb_buf = 1'b0;
      rst_n_i     = 1'b0;
      usb_cen_i   = 1'b1;
      usb_alen_i  = 1'b1;
      usb_wrn_i   = 1'b1;
      usb_rdn_i   = 1'b1;
      usb_addr_i  = '0;
      usb_din_i   = '0;
      target_io_i = 4'h0;

      add_test("mask_wr",       OP_WR,   REG_TRIG_MASK, 16'h00A5, 16'h0000);
      add_test("mask_rd",       OP_RD,   REG_TRIG_MASK, 16'h0000, 16'h00A5);
      add_test("ctrl_wr",       OP_WR,   REG_IO_CTRL,   16'h003C, 16'h0000);
      add_test("ctrl_rd",       OP_RD,   REG_IO_CTRL,   16'h0000, 16'h003C);
      add_test("unmapped_rd",   OP_RD,   8'h20,         16'h0000, 16'h0000);
      add_test("io_ctrl_a",     OP_IO,   REG_IO_CTRL,   16'h00A5, 16'h00A5);
      add_test("io_ctrl_b",     OP_IO,   REG_IO_CTRL,   16'h005F, 16'h005F);
      // data[11:8] target inputs, data[7:0] mask
      add_test("trig_io3",      OP_TRIG, REG_TRIG_MASK, 16'h0405, 16'h0001);
      add_test("trig_miss",     OP_TRIG, REG_TRIG_MASK, 16'h0A05, 16'h0000);
      add_test("trig_all",      OP_TRIG, REG_TRIG_MASK, 16'h080F, 16'h0001);
      add_test("trig_off",      OP_TRIG, REG_TRIG_MASK, 16'h0F00, 16'h0000);
      add_test("trig_io4_miss", OP_TRIG, REG_TRIG_MASK, 16'h0708, 16'h0000);
      add_test("trig_io4",      OP_TRIG, REG_TRIG_MASK, 16'h0808, 16'h0001);
      add_test("adc_xfer_a",    OP_XFER, REG_ADC_CFG,   16'hC35A, 16'h0000);
      add_test("cfg_rd",        OP_RD2,  REG_ADC_CFG,   16'h0000, 16'hC35A);
      add_test("stat_busy_rd",  OP_BUSY, REG_ADC_STAT,  16'h3A96, 16'h0001);
      add_test("adc_xfer_b",    OP_XFER, REG_ADC_CFG,   16'h1E81, 16'h0000);
      add_test("adc_error",     OP_ERR,  REG_ADC_CFG,   16'h6D29, 16'h0002);
      table_built = 1'b1;

      repeat (3) @(posedge clk_usb_buf);
      rst_n_i <= 1'b1;

      for (i = 0; i < tname_q.size(); i++) begin
         err_before = err_cnt;
         run_test(tname_q[i], op_q[i], addr_q[i], data_q[i], exp_q[i]);
         $display("test %-14s %s", tname_q[i], (err_cnt == err_before) ? "ok" : "failed");
      end

      repeat (4) @(posedge clk_usb_buf);
      err_cnt = err_cnt + u_dut.u_sva.assert_fails;
      $display("tests run %0d, errors %0d", tname_q.size(), err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- bench/cw_usb_regs_sva.sv
`timescale 1ns/10ps

module cw_usb_regs_sva (
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic reg_read_i,
   input  logic reg_write_i,
   input  logic adc_sclk_i,
   input  logic adc_sen_i
);

   int assert_fails = 0;   // failed assertion count

   a_no_rd_wr : assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(reg_read_i && reg_write_i))
      else begin
         assert_fails++;
         $error("reg_read and reg_write high together");
      end

   // strobes are single cycle pulses
   a_read_pulse : assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      reg_read_i |=> !reg_read_i)
      else begin
         assert_fails++;
         $error("reg_read longer than one cycle");
      end

   a_write_pulse : assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      reg_write_i |=> !reg_write_i)
      else begin
         assert_fails++;
         $error("reg_write longer than one cycle");
      end

   a_sclk_idle : assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      adc_sen_i |-> adc_sclk_i)   // serial clock parks high
      else begin
         assert_fails++;
         $error("adc_sclk low while adc_sen high");
      end

endmodule

bind cw_usb_regs_top cw_usb_regs_sva u_sva (
   .clk_usb_buf (clk_usb_buf),
   .rst_n_i     (rst_n_i),
   .reg_read_i  (reg_read),
   .reg_write_i (reg_write),
   .adc_sclk_i  (adc_sclk_o),
   .adc_sen_i   (adc_sen_o)
);

//--- logic/cw_usb_regs_top.sv
`timescale 1ns/10ps

module cw_usb_regs_top #(
   parameter int pBYTECNT_SIZE = 7,
   parameter int pSCLK_DIV     = 2,
   parameter int pBEAT_WIDTH   = 25
) (
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,

   // host bus
   input  logic                  usb_cen_i,
   input  logic                  usb_alen_i,
   input  logic                  usb_wrn_i,
   input  logic                  usb_rdn_i,
   input  cw_reg_pkg::reg_addr_t usb_addr_i,
   input  cw_reg_pkg::reg_data_t usb_din_i,
   output cw_reg_pkg::reg_data_t usb_dout_o,
   output logic                  usb_isout_o,

   // target I/O
   input  logic [3:0]            target_io_i,
   output logic                  trig_out_o,
   output logic [3:0]            target_oe_o,
   output logic [3:0]            target_out_o,

   // ADC setup port
   output logic                  adc_sclk_o,
   output logic                  adc_sdata_o,
   output logic                  adc_sen_o,
   input  logic                  adc_sdout_i,

   // LEDs
   output logic                  led_beat_o,
   output logic                  led_clk1fail_o,
   output logic                  led_clk2fail_o
);

   import cw_reg_pkg::*;

   reg_addr_t                reg_address;
   logic [pBYTECNT_SIZE-1:0] reg_bytecnt;
   reg_data_t                write_data;
   reg_data_t                read_data;
   reg_data_t                read_data_io;
   reg_data_t                read_data_adc;
   logic                     reg_read;
   logic                     reg_write;
   logic                     adc_error;

   // unselected blocks return zero
   assign read_data = read_data_io | read_data_adc;

   usb_reg_bridge #(
      .pBYTECNT_SIZE  (pBYTECNT_SIZE)
   ) u_bridge (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .usb_cen_i      (usb_cen_i),
      .usb_alen_i     (usb_alen_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_addr_i     (usb_addr_i),
      .usb_din_i      (usb_din_i),
      .usb_dout_o     (usb_dout_o),
      .usb_isout_o    (usb_isout_o),
      .reg_address_o  (reg_address),
      .reg_bytecnt_o  (reg_bytecnt),
      .reg_datao_o    (write_data),
      .reg_datai_i    (read_data),
      .reg_read_o     (reg_read),
      .reg_write_o    (reg_write)
   );

   reg_target_io #(
      .pBYTECNT_SIZE  (pBYTECNT_SIZE)
   ) u_target_io (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_address_i  (reg_address),
      .reg_bytecnt_i  (reg_bytecnt),
      .reg_datai_i    (write_data),
      .reg_datao_o    (read_data_io),
      .reg_read_i     (reg_read),
      .reg_write_i    (reg_write),
      .target_io_i    (target_io_i),
      .trig_out_o     (trig_out_o),
      .target_oe_o    (target_oe_o),
      .target_out_o   (target_out_o)
   );

   reg_adc_serial #(
      .pBYTECNT_SIZE  (pBYTECNT_SIZE),
      .pSCLK_DIV      (pSCLK_DIV)
   ) u_adc_serial (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_address_i  (reg_address),
      .reg_bytecnt_i  (reg_bytecnt),
      .reg_datai_i    (write_data),
      .reg_datao_o    (read_data_adc),
      .reg_read_i     (reg_read),
      .reg_write_i    (reg_write),
      .adc_sclk_o     (adc_sclk_o),
      .adc_sdata_o    (adc_sdata_o),
      .adc_sen_o      (adc_sen_o),
      .adc_sdout_i    (adc_sdout_i),
      .error_o        (adc_error)
   );

   status_leds #(
      .pBEAT_WIDTH    (pBEAT_WIDTH)
   ) u_status_leds (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .error_i        (adc_error),
      .led_beat_o     (led_beat_o),
      .led_clk1fail_o (led_clk1fail_o),
      .led_clk2fail_o (led_clk2fail_o)
   );

endmodule

//--- logic/status_leds.sv
`timescale 1ns/10ps

module status_leds #(
   parameter int pBEAT_WIDTH = 25
) (
   input  logic clk_usb_buf,
   input  logic rst_n_i,

   input  logic error_i,
   output logic led_beat_o,
   output logic led_clk1fail_o,
   output logic led_clk2fail_o
);

   logic [pBEAT_WIDTH-1:0] beat_cnt;
   logic                   beat;

   // free running, wraps
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         beat_cnt <= '0;
      end else begin
         beat_cnt <= beat_cnt + pBEAT_WIDTH'(1);
      end
   end

   assign beat = beat_cnt[pBEAT_WIDTH-1];

   assign led_beat_o = beat;

   // red LEDs flash only while an error is pending
   assign led_clk1fail_o = error_i & beat;
   assign led_clk2fail_o = error_i & beat;

endmodule

//--- logic/reg_adc_serial.sv
`timescale 1ns/10ps

module reg_adc_serial #(
   parameter int pBYTECNT_SIZE = 7,
   parameter int pSCLK_DIV     = 2
) (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,

   input  cw_reg_pkg::reg_addr_t     reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0]  reg_bytecnt_i,
   input  cw_reg_pkg::reg_data_t     reg_datai_i,
   output cw_reg_pkg::reg_data_t     reg_datao_o,
   input  logic                      reg_read_i,
   input  logic                      reg_write_i,

   // three-wire ADC setup port
   output logic                      adc_sclk_o,
   output logic                      adc_sdata_o,
   output logic                      adc_sen_o,
   input  logic                      adc_sdout_i,
   output logic                      error_o
);

   import cw_reg_pkg::*;

   localparam int DIV_W = (pSCLK_DIV > 1) ? $clog2(pSCLK_DIV) : 1;

   typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_DONE} adc_state_t;

   adc_state_t       state;
   adc_word_t        cfg_word;
   adc_word_t        tx_sh;
   reg_data_t        rx_sh;
   reg_data_t        reply;
   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       bit_cnt;
   logic             busy;
   logic             byte0;
   logic             byte1;
   logic             cfg_wr;
   logic             half_done;

   assign busy      = (state != ST_IDLE);
   assign byte0     = (reg_bytecnt_i == pBYTECNT_SIZE'(0));
   assign byte1     = (reg_bytecnt_i == pBYTECNT_SIZE'(1));
   assign cfg_wr    = reg_write_i && (reg_address_i == REG_ADC_CFG);
   assign half_done = (div_cnt == DIV_W'(pSCLK_DIV - 1));

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= ST_IDLE;
         cfg_word    <= '0;
         tx_sh       <= '0;
         rx_sh       <= '0;
         reply       <= '0;
         div_cnt     <= '0;
         bit_cnt     <= '0;
         adc_sclk_o  <= 1'b1;
         adc_sdata_o <= 1'b0;
         adc_sen_o   <= 1'b1;
         error_o     <= 1'b0;
      end else begin
         if (cfg_wr && busy) begin
            error_o <= 1'b1;   // write dropped, transfer keeps going
         end else if (reg_read_i && byte0 && reg_address_i == REG_ADC_STAT) begin
            error_o <= 1'b0;
         end

         case (state)
            ST_IDLE: begin
               if (cfg_wr && byte0) begin
                  cfg_word[15:8] <= reg_datai_i;
               end else if (cfg_wr && byte1) begin
                  cfg_word[7:0] <= reg_datai_i;
                  tx_sh         <= {cfg_word[14:8], reg_datai_i, 1'b0};
                  adc_sdata_o   <= cfg_word[15];   // MSB out first
                  adc_sen_o     <= 1'b0;
                  adc_sclk_o    <= 1'b0;
                  div_cnt       <= '0;
                  bit_cnt       <= '0;
                  state         <= ST_SHIFT;
               end
            end
            ST_SHIFT: begin
               if (!half_done) begin
                  div_cnt <= div_cnt + DIV_W'(1);
               end else begin
                  div_cnt <= '0;
                  if (!adc_sclk_o) begin
                     adc_sclk_o <= 1'b1;
                     rx_sh      <= {rx_sh[6:0], adc_sdout_i};   // rising edge sample
                  end else if (bit_cnt == 4'd15) begin
                     adc_sen_o   <= 1'b1;   // sclk stays high
                     adc_sdata_o <= 1'b0;
                     state       <= ST_DONE;
                  end else begin
                     adc_sclk_o  <= 1'b0;
                     adc_sdata_o <= tx_sh[15];
                     tx_sh       <= {tx_sh[14:0], 1'b0};
                     bit_cnt     <= bit_cnt + 4'd1;
                  end
               end
            end
            ST_DONE: begin
               reply <= rx_sh;   // last 8 samples
               state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            REG_ADC_CFG: begin
               if (byte0)      reg_datao_o = cfg_word[15:8];
               else if (byte1) reg_datao_o = cfg_word[7:0];
            end
            REG_ADC_STAT: begin
               if (byte0) begin
                  reg_datao_o[STAT_BUSY_BIT]  = busy;
                  reg_datao_o[STAT_ERROR_BIT] = error_o;
               end else if (byte1) begin
                  reg_datao_o = reply;
               end
            end
            default: reg_datao_o = '0;
         endcase
      end
   end

endmodule

//--- logic/reg_target_io.sv
`timescale 1ns/10ps

module reg_target_io #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,

   input  cw_reg_pkg::reg_addr_t     reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0]  reg_bytecnt_i,
   input  cw_reg_pkg::reg_data_t     reg_datai_i,
   output cw_reg_pkg::reg_data_t     reg_datao_o,
   input  logic                      reg_read_i,
   input  logic                      reg_write_i,

   input  logic [3:0]                target_io_i,
   output logic                      trig_out_o,
   output logic [3:0]                target_oe_o,
   output logic [3:0]                target_out_o
);

   import cw_reg_pkg::*;

   reg_data_t trig_mask;
   reg_data_t io_ctrl;
   logic      byte0;

   assign byte0 = (reg_bytecnt_i == pBYTECNT_SIZE'(0));  // both registers are one byte wide

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         trig_mask <= '0;
         io_ctrl   <= '0;
      end else if (reg_write_i && byte0) begin
         case (reg_address_i)
            REG_TRIG_MASK: trig_mask <= reg_datai_i;
            REG_IO_CTRL:   io_ctrl   <= reg_datai_i;
            default: ;
         endcase
      end
   end

   // read mux, zero when not addressed
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i && byte0) begin
         case (reg_address_i)
            REG_TRIG_MASK: reg_datao_o = trig_mask;
            REG_IO_CTRL:   reg_datao_o = io_ctrl;
            default:       reg_datao_o = '0;
         endcase
      end
   end

   // any enabled input fires the trigger
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         trig_out_o <= 1'b0;
      end else begin
         trig_out_o <= |(trig_mask[3:0] & target_io_i);
      end
   end

   assign target_oe_o  = io_ctrl[3:0];
   assign target_out_o = io_ctrl[7:4];

endmodule

//--- logic/usb_reg_bridge.sv
`timescale 1ns/10ps

module usb_reg_bridge #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,

   // host bus, all strobes active low
   input  logic                      usb_cen_i,
   input  logic                      usb_alen_i,
   input  logic                      usb_wrn_i,
   input  logic                      usb_rdn_i,
   input  cw_reg_pkg::reg_addr_t     usb_addr_i,
   input  cw_reg_pkg::reg_data_t     usb_din_i,
   output cw_reg_pkg::reg_data_t     usb_dout_o,
   output logic                      usb_isout_o,

   // register side
   output cw_reg_pkg::reg_addr_t     reg_address_o,
   output logic [pBYTECNT_SIZE-1:0]  reg_bytecnt_o,
   output cw_reg_pkg::reg_data_t     reg_datao_o,
   input  cw_reg_pkg::reg_data_t     reg_datai_i,
   output logic                      reg_read_o,
   output logic                      reg_write_o
);

   logic bus_addr;
   logic bus_wr;
   logic bus_rd;

   // decoded host cycles
   assign bus_addr = ~usb_cen_i & ~usb_alen_i;
   assign bus_wr   = ~usb_cen_i & ~usb_wrn_i;
   assign bus_rd   = ~usb_cen_i & ~usb_rdn_i;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_write_o   <= 1'b0;
         reg_read_o    <= 1'b0;
         usb_isout_o   <= 1'b0;
         reg_address_o <= '0;
         reg_bytecnt_o <= '0;
         reg_datao_o   <= '0;
         usb_dout_o    <= '0;
      end else begin
         reg_write_o <= bus_wr;   // one pulse per bus cycle
         reg_read_o  <= bus_rd;
         usb_isout_o <= bus_rd;

         // write data travels alongside the write pulse
         if (bus_wr) begin
            reg_datao_o <= usb_din_i;
         end

         if (bus_addr) begin
            reg_address_o <= usb_addr_i;
            reg_bytecnt_o <= '0;   // new register, restart at byte 0
         end else if (reg_write_o || reg_read_o) begin
            reg_bytecnt_o <= reg_bytecnt_o + pBYTECNT_SIZE'(1);
         end

         // block answers combinationally during the read pulse
         if (reg_read_o) begin
            usb_dout_o <= reg_datai_i;
         end
      end
   end

endmodule

//--- logic/cw_reg_pkg.sv
package cw_reg_pkg;

   // bus widths
   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_data_t;

   // setup word shifted out to the ADC, MSB first
   typedef logic [15:0] adc_word_t;

   // register map
   localparam reg_addr_t REG_TRIG_MASK = 8'h08;  // bits 3..0 select target io1..io4
   localparam reg_addr_t REG_IO_CTRL   = 8'h09;  // [3:0] output enables, [7:4] output values
   localparam reg_addr_t REG_ADC_CFG   = 8'h0A;  // byte 0 high, byte 1 low, byte 1 launches
   localparam reg_addr_t REG_ADC_STAT  = 8'h0B;  // read only

   // status byte 0 layout
   localparam int STAT_BUSY_BIT  = 0;
   localparam int STAT_ERROR_BIT = 1;

endpackage
